// File: common/icache_pkg.sv
package icache_pkg;

    // fetch and refill are one 32-bit word wide
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // byte offset inside a word, always zero on the fetch side
    localparam int offset_bits = 2;

    // 16 lines unless the top level says otherwise
    localparam int default_index_bits = 4;

    // performance counter width
    localparam int stat_w = 16;

    // fetch request from the front end
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } cpu_req_t;

    // instruction word back to the front end
    typedef struct packed {
        logic [data_w-1:0] data;
    } cpu_rsp_t;

    // refill request towards the backing memory
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } mem_req_t;

    // saturating hit and miss counts
    typedef struct packed {
        logic [stat_w-1:0] hits;
        logic [stat_w-1:0] misses;
    } stats_t;

endpackage

// File: icache/icache_store.sv
module icache_store #(
    parameter int index_bits = icache_pkg::default_index_bits,
    localparam int tag_w = icache_pkg::addr_w - index_bits - icache_pkg::offset_bits
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [index_bits-1:0]         rd_index,
    output logic                          rd_valid,
    output logic [tag_w-1:0]              rd_tag,
    output logic [icache_pkg::data_w-1:0] rd_data,

    input  logic                          wr_en,
    input  logic [index_bits-1:0]         wr_index,
    input  logic [tag_w-1:0]              wr_tag,
    input  logic [icache_pkg::data_w-1:0] wr_data,

    input  logic                          clr_en,
    input  logic [index_bits-1:0]         clr_index
);

    localparam int lines = 1 << index_bits;

    logic [lines-1:0]              valid_q;
    logic [tag_w-1:0]              tag_mem [lines];
    logic [icache_pkg::data_w-1:0] data_mem [lines];

    // valid bits live in flops so reset and flush can clear them
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (clr_en)
                valid_q[clr_index] <= 1'b0;
            if (wr_en)
                valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= valid_q[rd_index];
    end

    always_ff @(posedge clk)
    begin
        rd_tag  <= tag_mem[rd_index];
        rd_data <= data_mem[rd_index];
    end

endmodule

// File: icache/icache_ctrl.sv
module icache_ctrl #(
    parameter int index_bits = icache_pkg::default_index_bits,
    localparam int tag_w = icache_pkg::addr_w - index_bits - icache_pkg::offset_bits
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          cpu_req_valid,
    input  icache_pkg::cpu_req_t          cpu_req,
    input  logic                          flush,
    output logic                          cpu_ready,
    output logic                          cpu_rsp_valid,
    output icache_pkg::cpu_rsp_t          cpu_rsp,

    output logic                          mem_req_valid,
    output icache_pkg::mem_req_t          mem_req,
    input  logic                          mem_rsp_valid,
    input  logic [icache_pkg::data_w-1:0] mem_rsp_data,

    output logic [index_bits-1:0]         rd_index,
    input  logic                          rd_valid,
    input  logic [tag_w-1:0]              rd_tag,
    input  logic [icache_pkg::data_w-1:0] rd_data,
    output logic                          wr_en,
    output logic [index_bits-1:0]         wr_index,
    output logic [tag_w-1:0]              wr_tag,
    output logic [icache_pkg::data_w-1:0] wr_data,
    output logic                          clr_en,
    output logic [index_bits-1:0]         clr_index,

    output logic                          hit,
    output logic                          miss
);

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_refill,
        st_reread,
        st_flush
    } state_t;

    state_t                        state;
    state_t                        state_next;
    logic [icache_pkg::addr_w-1:0] req_addr;
    logic [index_bits-1:0]         req_index;
    logic [tag_w-1:0]              req_tag;
    logic [index_bits-1:0]         flush_cnt;
    logic                          refilled;
    logic                          accept;
    logic                          tag_match;

    assign req_index = req_addr[icache_pkg::offset_bits +: index_bits];
    assign req_tag   = req_addr[icache_pkg::addr_w-1 -: tag_w];

    // flush wins over a fetch in the same cycle
    assign accept    = (state == st_idle) && cpu_req_valid && !flush;
    assign tag_match = rd_valid && (rd_tag == req_tag);

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (flush)
                    state_next = st_flush;
                else if (cpu_req_valid)
                    state_next = st_compare;
            end
            st_compare:
            begin
                if (tag_match)
                    state_next = st_idle;
                else
                    state_next = st_refill;
            end
            st_refill:
            begin
                if (mem_rsp_valid)
                    state_next = st_reread;
            end
            st_reread:
                state_next = st_compare;
            st_flush:
            begin
                if (flush_cnt == '1)
                    state_next = st_idle;
            end
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_idle;
            refilled  <= 1'b0;
            flush_cnt <= '0;
        end
        else
        begin
            state <= state_next;

            // the compare after a refill is not a hit of its own
            if (accept)
                refilled <= 1'b0;
            else if (state == st_refill && mem_rsp_valid)
                refilled <= 1'b1;

            if (state == st_flush)
                flush_cnt <= flush_cnt + 1'b1;
            else
                flush_cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= cpu_req.addr;
    end

    // index goes straight to the store so the tags are ready in compare
    assign rd_index = (state == st_idle)
                    ? cpu_req.addr[icache_pkg::offset_bits +: index_bits]
                    : req_index;

    assign cpu_ready     = (state == st_idle);
    assign cpu_rsp_valid = (state == st_compare) && tag_match;

    always_comb
    begin
        cpu_rsp.data = rd_data;
    end

    assign hit  = (state == st_compare) && tag_match && !refilled;
    assign miss = (state == st_compare) && !tag_match;

    // held level until the memory answers
    assign mem_req_valid = (state == st_refill);

    always_comb
    begin
        mem_req.addr = {req_addr[icache_pkg::addr_w-1:icache_pkg::offset_bits],
                        {icache_pkg::offset_bits{1'b0}}};
    end

    assign wr_en    = (state == st_refill) && mem_rsp_valid;
    assign wr_index = req_index;
    assign wr_tag   = req_tag;
    assign wr_data  = mem_rsp_data;

    assign clr_en    = (state == st_flush);
    assign clr_index = flush_cnt;

endmodule

// File: rtl/icache_stats.sv
module icache_stats (
    input  logic               clk,
    input  logic               rst,
    input  logic               hit,
    input  logic               miss,
    output icache_pkg::stats_t stats
);

    // hold at all ones instead of wrapping
    function automatic logic [icache_pkg::stat_w-1:0] sat_inc(
        input logic [icache_pkg::stat_w-1:0] value
    );
        logic [icache_pkg::stat_w-1:0] result;

        if (value == '1)
            result = value;
        else
            result = value + 1'b1;
        return result;
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stats <= '0;
        end
        else
        begin
            if (hit)
                stats.hits <= sat_inc(stats.hits);
            if (miss)
                stats.misses <= sat_inc(stats.misses);
        end
    end

endmodule

// File: rtl/icache_top.sv
module icache_top #(
    parameter int index_bits = icache_pkg::default_index_bits,
    localparam int tag_w = icache_pkg::addr_w - index_bits - icache_pkg::offset_bits
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          cpu_req_valid,
    input  icache_pkg::cpu_req_t          cpu_req,
    input  logic                          flush,
    output logic                          cpu_ready,
    output logic                          cpu_rsp_valid,
    output icache_pkg::cpu_rsp_t          cpu_rsp,

    output logic                          mem_req_valid,
    output icache_pkg::mem_req_t          mem_req,
    input  logic                          mem_rsp_valid,
    input  logic [icache_pkg::data_w-1:0] mem_rsp_data,

    output icache_pkg::stats_t            stats
);

    logic [index_bits-1:0]         rd_index;
    logic                          rd_valid;
    logic [tag_w-1:0]              rd_tag;
    logic [icache_pkg::data_w-1:0] rd_data;
    logic                          wr_en;
    logic [index_bits-1:0]         wr_index;
    logic [tag_w-1:0]              wr_tag;
    logic [icache_pkg::data_w-1:0] wr_data;
    logic                          clr_en;
    logic [index_bits-1:0]         clr_index;
    logic                          hit;
    logic                          miss;

    icache_ctrl #(
        .index_bits (index_bits)
    ) icache_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .flush         (flush),
        .cpu_ready     (cpu_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp       (cpu_rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .rd_index      (rd_index),
        .rd_valid      (rd_valid),
        .rd_tag        (rd_tag),
        .rd_data       (rd_data),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_tag        (wr_tag),
        .wr_data       (wr_data),
        .clr_en        (clr_en),
        .clr_index     (clr_index),
        .hit           (hit),
        .miss          (miss)
    );

    icache_store #(
        .index_bits (index_bits)
    ) icache_store_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (rd_index),
        .rd_valid  (rd_valid),
        .rd_tag    (rd_tag),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .wr_data   (wr_data),
        .clr_en    (clr_en),
        .clr_index (clr_index)
    );

    icache_stats icache_stats_inst (
        .clk   (clk),
        .rst   (rst),
        .hit   (hit),
        .miss  (miss),
        .stats (stats)
    );

endmodule

// File: sim/tb_mem_model.sv
module tb_mem_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_req_valid,
    input  icache_pkg::mem_req_t          mem_req,
    output logic                          mem_rsp_valid,
    output logic [icache_pkg::data_w-1:0] mem_rsp_data
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] mem_xor = 32'hc0de_0000;
    localparam int max_delay = 5;

    logic [31:0] seed = 32'hdae1e002;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one refill at a time, answered after 0 to max_delay cycles
    initial
    begin
        logic [31:0] addr;
        int          delay;

        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!rst && mem_req_valid)
            begin
                addr  = mem_req.addr;
                seed  = lcg_next(seed);
                // upper bits of the lcg are the better ones
                delay = int'(seed[31:16]) % (max_delay + 1);
                repeat (delay)
                begin
                    @(posedge clk);
                    #1;
                end
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = addr ^ mem_xor;
                @(posedge clk);
                #1;
                mem_rsp_valid = 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_icache.sv
module tb_icache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int index_bits = icache_pkg::default_index_bits;
    localparam int lines = 1 << index_bits;
    localparam logic [31:0] mem_xor = 32'hc0de_0000;

    typedef struct packed {
        logic        is_flush;
        logic [31:0] addr;
        logic        exp_hit;
    } row_t;

    localparam int n_rows = 16;
    localparam int watchdog_cycles = n_rows * 20 + lines + 10;

    // flush op, fetch address, expected hit
    localparam row_t rows [n_rows] = '{
        '{1'b0, 32'h0000_1000, 1'b0},
        '{1'b0, 32'h0000_1000, 1'b1},
        '{1'b0, 32'h0000_1004, 1'b0},
        '{1'b0, 32'h0000_1004, 1'b1},
        '{1'b0, 32'h0000_2000, 1'b0},
        '{1'b0, 32'h0000_1000, 1'b0},
        '{1'b0, 32'h0000_2000, 1'b0},
        '{1'b0, 32'h0000_1000, 1'b0},
        '{1'b0, 32'h0000_1000, 1'b1},
        '{1'b1, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_1000, 1'b0},
        '{1'b0, 32'h0000_1004, 1'b0},
        '{1'b0, 32'h0000_1004, 1'b1},
        '{1'b0, 32'h0000_3038, 1'b0},
        '{1'b0, 32'h0000_3038, 1'b1},
        '{1'b0, 32'h0000_103c, 1'b0}
    };

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          cpu_req_valid;
    icache_pkg::cpu_req_t          cpu_req;
    logic                          flush;
    logic                          cpu_ready;
    logic                          cpu_rsp_valid;
    icache_pkg::cpu_rsp_t          cpu_rsp;
    logic                          mem_req_valid;
    icache_pkg::mem_req_t          mem_req;
    logic                          mem_rsp_valid;
    logic [icache_pkg::data_w-1:0] mem_rsp_data;
    icache_pkg::stats_t            stats;

    int          error_count = 0;
    int          check_count = 0;
    int          mem_req_count = 0;
    int          hit_rows = 0;
    int          miss_rows = 0;
    logic [31:0] last_mem_addr = '0;
    logic [31:0] prev_mem_addr = '0;
    logic        prev_mem_valid = 1'b0;

    always #5 clk = ~clk;

    icache_top #(
        .index_bits (index_bits)
    ) icache_top_inst (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .flush         (flush),
        .cpu_ready     (cpu_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp       (cpu_rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .stats         (stats)
    );

    tb_mem_model mem_model_inst (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t ns %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // mid-cycle view of the memory side
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (mem_req_valid && prev_mem_valid)
                check("mem_req.addr", mem_req.addr, prev_mem_addr);
            if (mem_req_valid && !prev_mem_valid)
            begin
                mem_req_count++;
                last_mem_addr = mem_req.addr;
            end
            if (mem_req_valid)
                check("cpu_ready", cpu_ready, 1'b0);
        end
        prev_mem_valid = mem_req_valid;
        prev_mem_addr  = mem_req.addr;
    end

    task automatic wait_ready();
        while (cpu_ready !== 1'b1)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic exp_hit);
        int lat;
        int reqs_before;

        wait_ready();
        reqs_before   = mem_req_count;
        cpu_req_valid = 1'b1;
        cpu_req.addr  = addr;
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
        lat = 1;
        while (cpu_rsp_valid !== 1'b1)
        begin
            check("cpu_ready", cpu_ready, 1'b0);
            @(posedge clk);
            #1;
            lat++;
        end
        check("cpu_ready", cpu_ready, 1'b0);
        check("cpu_rsp.data", cpu_rsp.data, addr ^ mem_xor);
        if (exp_hit)
        begin
            check("latency", lat, 1);
            check("mem requests", mem_req_count - reqs_before, 0);
        end
        else
        begin
            check("mem requests", mem_req_count - reqs_before, 1);
            check("mem_req.addr", last_mem_addr, addr);
        end
    endtask

    task automatic run_flush();
        int low_cycles;

        wait_ready();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        low_cycles = 0;
        while (cpu_ready !== 1'b1)
        begin
            low_cycles++;
            @(posedge clk);
            #1;
        end
        check("flush busy cycles", low_cycles, lines);
    endtask

    initial
    begin
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        flush         = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < n_rows; i++)
        begin
            if (rows[i].is_flush)
            begin
                run_flush();
            end
            else
            begin
                if (rows[i].exp_hit)
                    hit_rows++;
                else
                    miss_rows++;
                run_fetch(rows[i].addr, rows[i].exp_hit);
            end
        end

        // counters lag the compare cycle by one clock
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
        check("stats.hits", stats.hits, hit_rows);
        check("stats.misses", stats.misses, miss_rows);

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(watchdog_cycles * 10);
        $display("watchdog timeout, the test did not finish within %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: flist.f
common/icache_pkg.sv
icache/icache_store.sv
icache/icache_ctrl.sv
rtl/icache_stats.sv
rtl/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_icache -f flist.f -o Vtb_icache

output=$(./obj_dir/Vtb_icache)
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"
then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
